/* dv/lsm_tb.sv */
`timescale 1ns/1ps
`include "lsm_cfg.svh"

module lsm_tb;

	localparam int run_cycles = 36;							// Full load list with writeback.
	localparam int num_runs = 25;							// Bound on runs started below.
	localparam int watchdog_cycles = 2 * num_runs * (run_cycles + 4);

	logic clk;
	logic reset;
	logic start;
	logic [`LSM_DATA_W-1:0] ir;
	logic busy;
	logic done;
	logic illegal;
	logic [`LSM_REG_AW-1:0] rf_addr;
	logic [`LSM_DATA_W-1:0] rf_wdata;
	logic [`LSM_DATA_W-1:0] rf_rdata;
	logic rf_we;
	logic [`LSM_DATA_W-1:0] mem_addr;
	logic [`LSM_DATA_W-1:0] mem_wdata;
	logic [`LSM_DATA_W-1:0] mem_rdata;
	logic mem_we;
	logic mem_re;
	logic [`LSM_DATA_W-1:0] rf [`LSM_NUM_REGS];				// Register file model.
	logic [`LSM_DATA_W-1:0] mem [64];						// Word memory model.

	lsm_unit lsm_unit_i
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.ir(ir),
		.busy(busy),
		.done(done),
		.illegal(illegal),
		.rf_addr(rf_addr),
		.rf_wdata(rf_wdata),
		.rf_rdata(rf_rdata),
		.rf_we(rf_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.mem_we(mem_we),
		.mem_re(mem_re)
	);

	always #20 clk = ~clk;									// 40 ns period.

	assign rf_rdata = rf[rf_addr];							// Combinational read port.

	always @(posedge clk)
	begin
		if (rf_we)
			rf[rf_addr] <= rf_wdata;
		if (mem_we)
			mem[mem_addr[7:2]] <= mem_wdata;
		if (mem_re)
			mem_rdata <= mem[mem_addr[7:2]];				// Valid the cycle after mem_re.
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "Run stopped at the first error.");
	endtask

	task automatic check_word(input string name, input logic [`LSM_DATA_W-1:0] got, exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_reg(input string name, input logic [`LSM_REG_AW-1:0] got, exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_op(input string name, input lsm_pkg::lsm_op_e got, exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// Block transfer word with condition AL.
	function automatic logic [`LSM_DATA_W-1:0] make_word(input logic p, input logic u,
		input logic w, input logic l, input logic [3:0] rn, input logic [15:0] list);
		return {4'he, 3'b100, p, u, 1'b0, w, l, rn, list};
	endfunction

	// Aligned base that keeps a full list inside the 64 word memory either way.
	function automatic logic [`LSM_DATA_W-1:0] pick_base();
		return 32'd64 + 32'd4 * ($urandom % 32'd31);
	endfunction

	// Sets Rn, predicts every bus cycle, runs one transfer and checks it. Poke restarts mid-run.
	task automatic run_xfer(input logic [`LSM_DATA_W-1:0] word, input logic [`LSM_DATA_W-1:0] base,
		input int poke);
		logic [`LSM_DATA_W-1:0] snap [`LSM_NUM_REGS];
		logic [`LSM_DATA_W-1:0] exp_rf [`LSM_NUM_REGS];
		logic [`LSM_DATA_W-1:0] addr_of [`LSM_NUM_REGS];
		logic [`LSM_DATA_W-1:0] exp_addr [$];
		logic [`LSM_DATA_W-1:0] exp_data [$];
		logic [`LSM_REG_AW-1:0] exp_reg [$];
		logic [`LSM_DATA_W-1:0] fill_data [$];
		logic [`LSM_REG_AW-1:0] fill_reg [$];
		logic [`LSM_DATA_W-1:0] wb_val;
		logic [`LSM_DATA_W-1:0] data;
		logic [`LSM_REG_AW-1:0] rn;
		lsm_pkg::lsm_op_e op;
		lsm_pkg::lsm_op_e seen_op;
		int n;
		int rank;
		int cycle;
		int latency;
		int wb_seen;
		rn = word[19:16];
		op = word[20] ? lsm_pkg::op_ldm : lsm_pkg::op_stm;
		n = $countones(word[15:0]);
		wb_val = word[23] ? base + 4 * n : base - 4 * n;	// Base plus or minus four per register.
		latency = 18 + ((op == lsm_pkg::op_ldm) ? n : 0) + (word[21] ? 1 : 0);
		@(posedge clk);
		#2;
		rf[rn] <= base;
		@(posedge clk);
		#2;
		snap = rf;
		exp_rf = rf;
		rank = 0;
		for (int r = 0; r < `LSM_NUM_REGS; r++)
		begin
			if (word[r])
			begin
				if (word[23])
					addr_of[r] = base + 4 * rank + (word[24] ? 4 : 0);
				else
					addr_of[r] = base - 4 * (n - rank) + (word[24] ? 0 : 4);	// Lowest reg lowest.
				data = (op == lsm_pkg::op_ldm) ? mem[addr_of[r][7:2]] : snap[r];
				exp_rf[r] = (op == lsm_pkg::op_ldm) ? data : snap[r];
				if (word[23])
				begin
					exp_addr.push_back(addr_of[r]);			// Ascending scan.
					exp_data.push_back(data);
					exp_reg.push_back(r[`LSM_REG_AW-1:0]);
				end
				else
				begin
					exp_addr.push_front(addr_of[r]);		// Descending scan.
					exp_data.push_front(data);
					exp_reg.push_front(r[`LSM_REG_AW-1:0]);
				end
				rank++;
			end
		end
		if (word[21])
			exp_rf[rn] = wb_val;							// Writeback beats a loaded Rn.
		start = 1'b1;
		ir = word;
		cycle = 0;
		wb_seen = 0;
		forever
		begin
			@(negedge clk);
			if (busy !== (cycle != 0))
				fail_run($sformatf("busy is wrong in cycle %0d after start", cycle));
			if (illegal)
				fail_run("illegal pulsed for a block transfer instruction");
			if (mem_we || mem_re)
			begin
				if (exp_addr.size() == 0)
					fail_run("Memory transfer with no listed register left");
				if (mem_we)
					seen_op = lsm_pkg::op_stm;
				else
					seen_op = lsm_pkg::op_ldm;
				check_op("transfer op", seen_op, op);
				check_word("mem_addr", mem_addr, exp_addr.pop_front());
				if (mem_we)
				begin
					check_reg("rf_addr", rf_addr, exp_reg.pop_front());
					check_word("mem_wdata", mem_wdata, exp_data.pop_front());
				end
				else
				begin
					fill_reg.push_back(exp_reg.pop_front());	// Lands next cycle.
					fill_data.push_back(exp_data.pop_front());
				end
			end
			if (rf_we)
			begin
				if (fill_reg.size() != 0)
				begin
					check_reg("rf_addr", rf_addr, fill_reg.pop_front());
					check_word("rf_wdata", rf_wdata, fill_data.pop_front());
				end
				else if (word[21] && wb_seen == 0)
				begin
					check_reg("rf_addr", rf_addr, rn);
					check_word("rf_wdata", rf_wdata, wb_val);
					wb_seen = 1;
				end
				else
					fail_run("Register write with no load or writeback pending");
			end
			if (done)
				break;
			if (cycle >= run_cycles)
				fail_run("done did not arrive within the run bound");
			@(posedge clk);
			#2;
			cycle++;
			start = (cycle == poke);
			ir = (cycle == poke) ? word ^ 32'h0020_ffff : word;	// Flips W and the list.
		end
		check_word("done cycle", cycle, latency);
		if (exp_addr.size() != 0 || fill_reg.size() != 0)
			fail_run("Not every listed register was transferred");
		if (word[21] && wb_seen == 0)
			fail_run("Writeback to Rn is missing");
		@(posedge clk);
		#2;
		start = 1'b0;
		@(negedge clk);
		if (busy)
			fail_run("A start during busy began a new transfer");
		for (int r = 0; r < `LSM_NUM_REGS; r++)
			check_word($sformatf("r%0d", r), rf[r], exp_rf[r]);
		for (int r = 0; r < `LSM_NUM_REGS; r++)
			if (word[r] && op == lsm_pkg::op_stm)
				check_word($sformatf("mem[0x%h]", addr_of[r]), mem[addr_of[r][7:2]], snap[r]);
	endtask

	// Status and strobes come out of reset low.
	task automatic test_reset_state();
		@(negedge clk);
		if (busy || done || illegal || rf_we || mem_we || mem_re)
			fail_run("A status or strobe output is high after reset");
	endtask

	task automatic test_store_post_inc();
		for (int i = 0; i < 3; i++)
			run_xfer(make_word(1'b0, 1'b1, 1'b0, 1'b0, 4'($urandom), 16'($urandom)), pick_base(), -1);
	endtask

	task automatic test_load_modes();
		for (int m = 0; m < 4; m++)
			for (int i = 0; i < 2; i++)
				run_xfer(make_word(m[1], m[0], 1'b0, 1'b1, 4'($urandom), 16'($urandom)),
					pick_base(), -1);								// P from bit 1, U from bit 0.
	endtask

	task automatic test_writeback();
		run_xfer(make_word(1'b0, 1'b1, 1'b1, 1'b0, 4'd13, 16'($urandom)), pick_base(), -1);
		run_xfer(make_word(1'b0, 1'b0, 1'b1, 1'b1, 4'd5, 16'($urandom) | 16'h0020),
			pick_base(), -1);										// Rn is in the list.
		run_xfer(make_word(1'b1, 1'b1, 1'b1, 1'b1, 4'd0, 16'($urandom) | 16'h0001),
			pick_base(), -1);
	endtask

	task automatic test_latency();
		run_xfer(make_word(1'b0, 1'b1, 1'b0, 1'b0, 4'd3, 16'h0000), pick_base(), -1);
		run_xfer(make_word(1'b1, 1'b0, 1'b1, 1'b0, 4'd7, 16'hffff), pick_base(), -1);
		run_xfer(make_word(1'b0, 1'b1, 1'b1, 1'b1, 4'd9, 16'hffff), pick_base(), -1);
		run_xfer(make_word(1'b1, 1'b1, 1'b0, 1'b1, 4'd4, 16'h0000), pick_base(), -1);
	endtask

	task automatic test_illegal_and_busy();
		logic [`LSM_DATA_W-1:0] word;
		word = make_word(1'b0, 1'b1, 1'b1, 1'b1, 4'd2, 16'hffff);
		word[27:25] = 3'b011;								// Not a block transfer.
		@(posedge clk);
		#2;
		start = 1'b1;
		ir = word;
		for (int c = 0; c < 6; c++)
		begin
			@(negedge clk);
			if (illegal !== (c == 1))
				fail_run("illegal is not a single pulse one cycle after start");
			if (busy || rf_we || mem_we || mem_re)
				fail_run("Refused instruction caused bus activity");
			@(posedge clk);
			#2;
			start = 1'b0;
		end
		run_xfer(make_word(1'b0, 1'b1, 1'b0, 1'b1, 4'd6, 16'($urandom)), pick_base(), 6);
	endtask

	initial
	begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles", watchdog_cycles);
		$display("TB FAILED");
		$fatal(1, "Simulation timeout.");
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		ir = '0;
		mem_rdata <= '0;
		void'($urandom(32'h547f_da67));
		for (int i = 0; i < `LSM_NUM_REGS; i++)
			rf[i] <= $urandom;
		for (int i = 0; i < 64; i++)
			mem[i] <= $urandom;
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
		test_reset_state();
		test_store_post_inc();
		test_load_modes();
		test_writeback();
		test_latency();
		test_illegal_and_busy();
		$display("TB PASSED");
		$finish;
	end

endmodule

/* dv/lsm_unit_assert.sv */
`timescale 1ns/1ps

module lsm_unit_assert
(
	input logic clk,										// Core clock.
	input logic reset,										// Synchronous reset.
	input logic start,
	input logic busy,
	input logic done,
	input logic illegal,
	input logic rf_we,
	input logic mem_we,
	input logic mem_re,
	input lsm_pkg::lsm_mode_t mode							// Latched addressing mode.
);

	one_dir_a: assert property (@(posedge clk) disable iff (reset) !(mem_we && mem_re))
		else $error("mem_we and mem_re are high together");

	done_pulse_a: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done is longer than one cycle");

	idle_quiet_a: assert property (@(posedge clk) disable iff (reset)
		!busy |-> !(rf_we || mem_we || mem_re))
		else $error("Strobe high while busy is low");

	// A start in flight must not reload the mode or be refused.
	busy_start_a: assert property (@(posedge clk) disable iff (reset)
		(start && busy) |=> ($stable(mode) && !illegal))
		else $error("start during busy was not ignored");

endmodule

bind lsm_unit lsm_unit_assert lsm_unit_assert_i
(
	.clk(clk),
	.reset(reset),
	.start(start),
	.busy(busy),
	.done(done),
	.illegal(illegal),
	.rf_we(rf_we),
	.mem_we(mem_we),
	.mem_re(mem_re),
	.mode(mode)
);

/* hdl/lsm_addr_gen.sv */
`timescale 1ns/1ps
`include "lsm_cfg.svh"

module lsm_addr_gen
(
	input  logic clk,								// Core clock.
	input  logic reset,								// Synchronous reset.
	input  logic addr_load,							// Capture the base.
	input  logic addr_step,							// Advance one word.
	input  lsm_pkg::lsm_mode_t mode,				// Up and pre select the indexing.
	input  logic [`LSM_DATA_W-1:0] base,			// Rn value from the register file.
	output logic [`LSM_DATA_W-1:0] mem_addr,		// Address of the current transfer.
	output logic [`LSM_DATA_W-1:0] wb_addr			// Value written back to Rn.
);

	logic [`LSM_DATA_W-1:0] cur_q;					// Current address.
	logic [`LSM_DATA_W-1:0] cur_next;				// Current address one word on.

	// The step direction follows U.
	always_comb
	begin
		if (mode.up)
			cur_next = cur_q + `LSM_DATA_W'(`LSM_WORD_BYTES);
		else
			cur_next = cur_q - `LSM_DATA_W'(`LSM_WORD_BYTES);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			cur_q <= '0;
		else if (addr_load)
			cur_q <= base;							// Start from Rn.
		else if (addr_step)
			cur_q <= cur_next;						// One word per transfer.
	end

	// Pre-index uses the stepped address before the step is taken.
	assign mem_addr = mode.pre ? cur_next : cur_q;

	// After N steps this is base plus or minus four times N.
	assign wb_addr = cur_q;

endmodule

/* hdl/lsm_cfg.svh */
`ifndef LSM_CFG_SVH
`define LSM_CFG_SVH

// Data path and address width of the core.
`define LSM_DATA_W 32

// Number of register list positions in a block transfer word.
`define LSM_NUM_REGS 16

// Byte distance between two consecutive transfers.
`define LSM_WORD_BYTES 4

// Width of a register address.
`define LSM_REG_AW $clog2(`LSM_NUM_REGS)

// Opcode field value of a block data transfer.
`define LSM_CLASS_BDT 3'b100

`endif

/* hdl/lsm_manager.sv */
`timescale 1ns/1ps
`include "lsm_cfg.svh"

module lsm_manager
(
	input  logic clk,								// Core clock.
	input  logic reset,								// Synchronous reset.
	input  lsm_pkg::lsm_ctrl_t ctrl,				// Load, shift and count.
	input  logic up,								// Scan upward from r0.
	input  logic [`LSM_NUM_REGS-1:0] reg_list,		// Register list of the instruction.
	output lsm_pkg::lsm_status_t status				// Detect, address and last.
);

	logic [`LSM_NUM_REGS-1:0] list_q;				// Shifting copy of the list.
	logic [`LSM_REG_AW-1:0] cnt_q;					// Register address counter.
	logic [`LSM_REG_AW-1:0] cnt_first;				// Preset value for the counter.
	logic [`LSM_REG_AW-1:0] cnt_final;				// Position that ends the scan.

	assign cnt_first = up ? '0 : '1;				// r0 going up, r15 going down.
	assign cnt_final = up ? '1 : '0;				// Opposite end of the list.

	// List shifter.
	always_ff @(posedge clk)
	begin
		if (reset)
			list_q <= '0;							// Nothing listed.
		else if (ctrl.load)
			list_q <= reg_list;						// Capture the whole list.
		else if (ctrl.shift)
		begin
			if (up)
				list_q <= list_q >> 1;				// Next higher register into bit 0.
			else
				list_q <= list_q << 1;				// Next lower register into the top bit.
		end
	end

	// Register address counter.
	always_ff @(posedge clk)
	begin
		if (reset)
			cnt_q <= '0;
		else if (ctrl.load)
			cnt_q <= cnt_first;						// Preset by direction.
		else if (ctrl.count)
		begin
			if (up)
				cnt_q <= cnt_q + 1'b1;				// Wraps after r15 and the scan is over by then.
			else
				cnt_q <= cnt_q - 1'b1;
		end
	end

	// Status is read straight from the registers.
	always_comb
	begin
		if (up)
			status.detect = list_q[0];					// Low end is scanned.
		else
			status.detect = list_q[`LSM_NUM_REGS-1];	// High end is scanned.
		status.reg_addr = cnt_q;					// Address of the scanned register.
		status.last = (cnt_q == cnt_final);			// Final list position.
	end

endmodule

/* hdl/lsm_pkg.sv */
`include "lsm_cfg.svh"

package lsm_pkg;

	// Control lines from the sequencer to the list manager.
	typedef struct packed
	{
		logic shift;								// Moves the list one position.
		logic count;								// Moves the register counter.
		logic load;									// Captures list and presets counter.
	} lsm_ctrl_t;

	// Status returned by the list manager.
	typedef struct packed
	{
		logic detect;								// Listed register at the scanned end.
		logic [`LSM_REG_AW-1:0] reg_addr;			// Register under scan.
		logic last;									// Counter sits at the final position.
	} lsm_status_t;

	// Transfer direction taken from the L bit.
	typedef enum logic
	{
		op_stm = 1'b0,								// Store multiple.
		op_ldm = 1'b1								// Load multiple.
	} lsm_op_e;

	// Sequencer states.
	typedef enum logic [2:0]
	{
		st_idle,									// Waiting for start.
		st_load,									// Base read and list load.
		st_step,									// One list position per cycle.
		st_fill,									// Load data lands in the register file.
		st_wb,										// Base register update.
		st_done										// Completion pulse.
	} lsm_state_e;

	// Addressing mode latched from the instruction.
	typedef struct packed
	{
		logic up;									// U bit.
		logic pre;									// P bit.
		logic wb;									// W bit.
		lsm_op_e op;								// L bit.
	} lsm_mode_t;

endpackage

/* hdl/lsm_sequencer.sv */
`timescale 1ns/1ps
`include "lsm_cfg.svh"

module lsm_sequencer
(
	input  logic clk,								// Core clock.
	input  logic reset,								// Synchronous reset.
	input  logic start,								// Start strobe.
	input  logic [`LSM_DATA_W-1:0] ir,				// Instruction word.
	input  lsm_pkg::lsm_status_t status,			// From the list manager.
	input  logic [`LSM_DATA_W-1:0] rf_rdata,		// Register file read data.
	input  logic [`LSM_DATA_W-1:0] mem_rdata,		// Memory read data.
	input  logic [`LSM_DATA_W-1:0] wb_addr,			// Final address for Rn.
	output lsm_pkg::lsm_ctrl_t ctrl,				// To the list manager.
	output lsm_pkg::lsm_mode_t mode,				// Latched addressing mode.
	output logic [`LSM_NUM_REGS-1:0] reg_list,		// Latched register list.
	output logic addr_load,							// Base capture.
	output logic addr_step,							// Address advance.
	output logic busy,								// Instruction in flight.
	output logic done,								// Completion pulse.
	output logic illegal,							// Refused instruction pulse.
	output logic [`LSM_REG_AW-1:0] rf_addr,			// Register file address.
	output logic [`LSM_DATA_W-1:0] rf_wdata,		// Register file write data.
	output logic rf_we,								// Register file write strobe.
	output logic [`LSM_DATA_W-1:0] mem_wdata,		// Memory write data.
	output logic mem_we,							// Memory write strobe.
	output logic mem_re								// Memory read strobe.
);

	lsm_pkg::lsm_state_e state_q;					// Current state.
	lsm_pkg::lsm_state_e state_d;					// Next state.
	lsm_pkg::lsm_state_e tail_state;				// State after the scan.
	logic [`LSM_REG_AW-1:0] rn_q;					// Base register number.
	logic [`LSM_REG_AW-1:0] fill_reg_q;				// Target of the pending load.
	logic fill_last_q;								// Pending load came from the last position.
	logic accept;									// Start taken in idle.
	logic legal;									// Block transfer class.
	logic xfer;										// One transfer this cycle.

	assign legal = (ir[27:25] == `LSM_CLASS_BDT);
	assign accept = start && (state_q == lsm_pkg::st_idle);	// Start is ignored while busy.
	assign tail_state = mode.wb ? lsm_pkg::st_wb : lsm_pkg::st_done;

	always_comb
	begin
		state_d = state_q;
		unique case (state_q)
			lsm_pkg::st_idle:
				if (accept && legal)
					state_d = lsm_pkg::st_load;
			lsm_pkg::st_load:
				state_d = lsm_pkg::st_step;		// List and base are in place.
			lsm_pkg::st_step:
				if (status.detect && (mode.op == lsm_pkg::op_ldm))
					state_d = lsm_pkg::st_fill;	// Data arrives next cycle.
				else if (status.last)
					state_d = tail_state;
			lsm_pkg::st_fill:
				if (fill_last_q)
					state_d = tail_state;
				else
					state_d = lsm_pkg::st_step;	// Resume the scan.
			lsm_pkg::st_wb:
				state_d = lsm_pkg::st_done;
			lsm_pkg::st_done:
				state_d = lsm_pkg::st_idle;
			default:
				state_d = lsm_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state_q <= lsm_pkg::st_idle;
			illegal <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			illegal <= accept && !legal;			// Takes the place of busy.
		end
	end

	// Instruction fields held for the whole transfer.
	always_ff @(posedge clk)
	begin
		if (accept && legal)
		begin
			mode.up <= ir[23];
			mode.pre <= ir[24];
			mode.wb <= ir[21];
			mode.op <= lsm_pkg::lsm_op_e'(ir[20]);
			rn_q <= ir[19:16];
			reg_list <= ir[`LSM_NUM_REGS-1:0];
		end
		if (state_q == lsm_pkg::st_step)
		begin
			fill_reg_q <= status.reg_addr;			// Manager moves on meanwhile.
			fill_last_q <= status.last;
		end
	end

	assign xfer = (state_q == lsm_pkg::st_step) && status.detect;

	// Manager control.
	assign ctrl.load = (state_q == lsm_pkg::st_load);
	assign ctrl.shift = (state_q == lsm_pkg::st_step);
	assign ctrl.count = (state_q == lsm_pkg::st_step);	// Moves together with the list.

	// Address generator control.
	assign addr_load = (state_q == lsm_pkg::st_load);
	assign addr_step = xfer;

	assign busy = (state_q != lsm_pkg::st_idle);
	assign done = (state_q == lsm_pkg::st_done);

	// Memory side.
	assign mem_we = xfer && (mode.op == lsm_pkg::op_stm);
	assign mem_re = xfer && (mode.op == lsm_pkg::op_ldm);
	assign mem_wdata = rf_rdata;					// Stored register read through.

	// Register file side.
	always_comb
	begin
		unique case (state_q)
			lsm_pkg::st_step:
				rf_addr = status.reg_addr;			// Source of a store.
			lsm_pkg::st_fill:
				rf_addr = fill_reg_q;				// Target of a load.
			default:
				rf_addr = rn_q;						// Base read and writeback.
		endcase
	end

	assign rf_we = (state_q == lsm_pkg::st_fill) || (state_q == lsm_pkg::st_wb);
	assign rf_wdata = (state_q == lsm_pkg::st_wb) ? wb_addr : mem_rdata;	// Writeback comes last.

endmodule

/* hdl/lsm_unit.sv */
`timescale 1ns/1ps
`include "lsm_cfg.svh"

module lsm_unit
(
	input  logic clk,								// Core clock.
	input  logic reset,								// Synchronous reset.
	input  logic start,								// Start strobe.
	input  logic [`LSM_DATA_W-1:0] ir,				// Instruction word.
	output logic busy,								// Instruction in flight.
	output logic done,								// Completion pulse.
	output logic illegal,							// Refused instruction pulse.
	output logic [`LSM_REG_AW-1:0] rf_addr,			// Register file address.
	output logic [`LSM_DATA_W-1:0] rf_wdata,		// Register file write data.
	input  logic [`LSM_DATA_W-1:0] rf_rdata,		// Register file read data.
	output logic rf_we,								// Register file write strobe.
	output logic [`LSM_DATA_W-1:0] mem_addr,		// Memory address.
	output logic [`LSM_DATA_W-1:0] mem_wdata,		// Memory write data.
	input  logic [`LSM_DATA_W-1:0] mem_rdata,		// Memory read data.
	output logic mem_we,							// Memory write strobe.
	output logic mem_re								// Memory read strobe.
);

	lsm_pkg::lsm_ctrl_t ctrl;						// Sequencer to manager.
	lsm_pkg::lsm_status_t status;					// Manager to sequencer.
	lsm_pkg::lsm_mode_t mode;						// Latched addressing mode.
	logic [`LSM_NUM_REGS-1:0] reg_list;				// Latched register list.
	logic addr_load;								// Base capture.
	logic addr_step;								// Address advance.
	logic [`LSM_DATA_W-1:0] wb_addr;				// Final address for Rn.

	lsm_sequencer sequencer_i
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.ir(ir),
		.status(status),
		.rf_rdata(rf_rdata),
		.mem_rdata(mem_rdata),
		.wb_addr(wb_addr),
		.ctrl(ctrl),
		.mode(mode),
		.reg_list(reg_list),
		.addr_load(addr_load),
		.addr_step(addr_step),
		.busy(busy),
		.done(done),
		.illegal(illegal),
		.rf_addr(rf_addr),
		.rf_wdata(rf_wdata),
		.rf_we(rf_we),
		.mem_wdata(mem_wdata),
		.mem_we(mem_we),
		.mem_re(mem_re)
	);

	lsm_manager manager_i
	(
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.up(mode.up),								// Scan direction follows U.
		.reg_list(reg_list),
		.status(status)
	);

	lsm_addr_gen addr_gen_i
	(
		.clk(clk),
		.reset(reset),
		.addr_load(addr_load),
		.addr_step(addr_step),
		.mode(mode),
		.base(rf_rdata),							// Rn is on the read port during the load state.
		.mem_addr(mem_addr),
		.wb_addr(wb_addr)
	);

endmodule

/* run_sim.sh */
#!/bin/sh
# Compiles the lsm_unit testbench with Verilator and runs it.
# The exit status is the simulator's own: nonzero after any $fatal.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
top=lsm_tb

if ! command -v verilator >/dev/null 2>&1
then
	echo "verilator not found in PATH"
	exit 1
fi

if ! rm -rf "$build_dir"
then
	echo "Could not clean $build_dir"
	exit 1
fi

verilator --binary --timing --assert -j 0 \
	--top-module "$top" --Mdir "$build_dir" \
	-f verilog.f
status=$?
if [ $status -ne 0 ]
then
	echo "Verilator build failed with status $status"
	exit $status
fi

"./$build_dir/V$top"
status=$?
if [ $status -ne 0 ]
then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0

/* verilog.f */
+incdir+hdl
hdl/lsm_pkg.sv
hdl/lsm_manager.sv
hdl/lsm_addr_gen.sv
hdl/lsm_sequencer.sv
hdl/lsm_unit.sv
dv/lsm_unit_assert.sv
dv/lsm_tb.sv
